/* verilog/window_pkg.sv */
package window_pkg;

  //////////////////////////////////////////////////
  // Stream beats
  //////////////////////////////////////////////////

  // One complex sample with I in the upper half
  typedef struct packed {
    logic [15:0] data_i;
    logic [15:0] data_q;
    logic        last;
  } sample_beat_t;

  // Window coefficient, signed Q1.15
  typedef struct packed {
    logic signed [15:0] coeff;
    logic               last;
  } coeff_beat_t;

  //////////////////////////////////////////////////
  // Settings bus addresses
  //////////////////////////////////////////////////

  localparam logic [7:0] SR_WINDOW_SIZE = 8'd32;
  // Each write pushes one coefficient
  localparam logic [7:0] SR_COEFF       = 8'd33;
  // Pushes the coefficient that closes the table
  localparam logic [7:0] SR_COEFF_LAST  = 8'd34;
  localparam logic [7:0] SR_READBACK    = 8'd255;

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  // Returned for any unused readback select
  localparam logic [63:0] RB_ERROR_WORD = 64'h0BAD_C0DE_0BAD_C0DE;

endpackage

/* verilog/setting_reg.sv */
module setting_reg #(
  parameter int               ADDR        = 0,
  parameter int               WIDTH       = 32,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             i_ce_clk,
  input  logic             i_arst_n,
  input  logic             i_set_stb,
  input  logic [7:0]       i_set_addr,
  input  logic [31:0]      i_set_data,
  output logic [WIDTH-1:0] o_value,
  output logic             o_changed
);

  logic hit;

  // Strobe aimed at this register
  assign hit = i_set_stb && (i_set_addr == 8'(ADDR));

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_value   <= RESET_VALUE;
      o_changed <= 1'b0;
    end else begin
      o_changed <= hit;
      if (hit) begin
        // Upper bits of the bus are dropped
        o_value <= i_set_data[WIDTH-1:0];
      end
    end
  end

endmodule

/* verilog/stream_fifo.sv */
module stream_fifo #(
  parameter type payload_t       = logic [31:0],
  parameter int  FIFO_DEPTH_LOG2 = 2
) (
  input  logic     i_ce_clk,
  input  logic     i_arst_n,
  // Upstream side
  input  payload_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  // Downstream side
  output payload_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

  payload_t                   mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       push;
  logic                       pop;

  assign o_ready = (count != (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  // Payload storage
  always_ff @(posedge i_ce_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* verilog/window_settings.sv */
module window_settings #(
  parameter int MAX_LOG2_WINDOW = 11
) (
  input  logic                     i_ce_clk,
  input  logic                     i_arst_n,
  // Settings bus
  input  logic                     i_set_stb,
  input  logic [7:0]               i_set_addr,
  input  logic [31:0]              i_set_data,
  // Decoded outputs
  output logic [MAX_LOG2_WINDOW:0] o_window_size,
  output window_pkg::coeff_beat_t  o_coeff,
  output logic                     o_coeff_valid,
  output logic [63:0]              o_rb_data
);

  localparam int MAX_WINDOW = 1 << MAX_LOG2_WINDOW;
  localparam int RB_SEL_WIDTH = 3;

  logic [31:0]             size_raw;
  logic [RB_SEL_WIDTH-1:0] rb_sel;
  logic                    coeff_hit;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  // Full word kept so large writes clamp instead of wrapping
  setting_reg #(
    .ADDR(window_pkg::SR_WINDOW_SIZE), .WIDTH(32), .RESET_VALUE(32'(MAX_WINDOW)))
  u_sr_window_size (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_value(size_raw), .o_changed());

  setting_reg #(
    .ADDR(window_pkg::SR_READBACK), .WIDTH(RB_SEL_WIDTH), .RESET_VALUE('0))
  u_sr_readback (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_value(rb_sel), .o_changed());

  // Zero or oversize means maximum window
  assign o_window_size = ((size_raw == '0) || (size_raw > 32'(MAX_WINDOW))) ?
                         (MAX_LOG2_WINDOW + 1)'(MAX_WINDOW) :
                         size_raw[MAX_LOG2_WINDOW:0];

  //////////////////////////////////////////////////
  // Coefficient beats
  //////////////////////////////////////////////////

  assign coeff_hit = i_set_stb &&
                     ((i_set_addr == window_pkg::SR_COEFF) ||
                      (i_set_addr == window_pkg::SR_COEFF_LAST));

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_coeff_valid <= 1'b0;
    end else begin
      o_coeff_valid <= coeff_hit;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (coeff_hit) begin
      o_coeff.coeff <= i_set_data[15:0];
      o_coeff.last  <= (i_set_addr == window_pkg::SR_COEFF_LAST);
    end
  end

  // Readback mux
  always_comb begin
    case (rb_sel)
      3'd0:    o_rb_data = 64'(MAX_WINDOW);
      3'd1:    o_rb_data = 64'(o_window_size);
      default: o_rb_data = window_pkg::RB_ERROR_WORD;
    endcase
  end

endmodule

/* verilog/window_core.sv */
module window_core #(
  parameter int MAX_LOG2_WINDOW = 11
) (
  input  logic                     i_ce_clk,
  input  logic                     i_arst_n,
  input  logic [MAX_LOG2_WINDOW:0] i_window_size,
  // Coefficient load
  input  window_pkg::coeff_beat_t  i_coeff,
  input  logic                     i_coeff_valid,
  output logic                     o_coeff_ready,
  // Sample in
  input  window_pkg::sample_beat_t i_tdata,
  input  logic                     i_tvalid,
  output logic                     o_tready,
  // Sample out
  output window_pkg::sample_beat_t o_tdata,
  output logic                     o_tvalid,
  input  logic                     i_tready
);

  localparam int DEPTH = 1 << MAX_LOG2_WINDOW;
  localparam int SW = MAX_LOG2_WINDOW + 1;

  logic signed [15:0]         coeff_mem [DEPTH];
  logic [MAX_LOG2_WINDOW-1:0] coeff_addr;

  logic [SW-1:0]              prev_size;
  logic                       size_changed;
  logic [MAX_LOG2_WINDOW-1:0] pos;
  logic [MAX_LOG2_WINDOW-1:0] pos_eff;
  logic                       pos_last;

  logic                       advance;
  logic                       accept;

  // Stage 1 holds the sample and its coefficient
  logic                       s1_valid;
  logic                       s1_last;
  logic signed [15:0]         s1_i;
  logic signed [15:0]         s1_q;
  logic signed [15:0]         s1_coeff;

  logic signed [31:0]         prod_i;
  logic signed [31:0]         prod_q;

  //////////////////////////////////////////////////
  // Coefficient memory
  //////////////////////////////////////////////////

  assign o_coeff_ready = 1'b1;

  always_ff @(posedge i_ce_clk) begin
    if (i_coeff_valid) begin
      coeff_mem[coeff_addr] <= i_coeff.coeff;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      coeff_addr <= '0;
    end else if (i_coeff_valid) begin
      // Table restarts after the last beat
      coeff_addr <= i_coeff.last ? '0 : coeff_addr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Position in window
  //////////////////////////////////////////////////

  assign size_changed = (i_window_size != prev_size);
  assign pos_eff      = size_changed ? '0 : pos;
  assign pos_last     = (SW'(pos_eff) == (i_window_size - SW'(1)));

  // Whole pipeline stalls when output is held
  assign advance  = !o_tvalid || i_tready;
  assign o_tready = advance;
  assign accept   = i_tvalid && advance;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      prev_size <= SW'(DEPTH);
      pos       <= '0;
    end else begin
      prev_size <= i_window_size;
      if (accept) begin
        pos <= pos_last ? '0 : pos_eff + 1'b1;
      end else begin
        pos <= pos_eff;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  assign prod_i = s1_i * s1_coeff;
  assign prod_q = s1_q * s1_coeff;

  always_ff @(posedge i_ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s1_valid <= 1'b0;
      o_tvalid <= 1'b0;
    end else if (advance) begin
      s1_valid <= i_tvalid;
      o_tvalid <= s1_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (accept) begin
      // Output last comes from the position counter
      s1_i     <= i_tdata.data_i;
      s1_q     <= i_tdata.data_q;
      s1_last  <= pos_last;
      s1_coeff <= coeff_mem[pos_eff];
    end
    if (advance && s1_valid) begin
      // Q1.15 scale by arithmetic shift of 15 and 16-bit truncation
      o_tdata.data_i <= prod_i[30:15];
      o_tdata.data_q <= prod_q[30:15];
      o_tdata.last   <= s1_last;
    end
  end

endmodule

/* verilog/noc_block_window.sv */
module noc_block_window #(
  parameter int MAX_LOG2_WINDOW = 11,
  parameter int FIFO_DEPTH_LOG2 = 2
) (
  input  logic                     i_ce_clk,
  input  logic                     i_arst_n,
  // Settings bus and readback
  input  logic                     i_set_stb,
  input  logic [7:0]               i_set_addr,
  input  logic [31:0]              i_set_data,
  output logic [63:0]              o_rb_data,
  // Sample stream in
  input  window_pkg::sample_beat_t i_tdata,
  input  logic                     i_tvalid,
  output logic                     o_tready,
  // Sample stream out
  output window_pkg::sample_beat_t o_tdata,
  output logic                     o_tvalid,
  input  logic                     i_tready
);

  logic [MAX_LOG2_WINDOW:0] window_size;

  window_pkg::coeff_beat_t  set_coeff;
  logic                     set_coeff_valid;
  window_pkg::coeff_beat_t  core_coeff;
  logic                     core_coeff_valid;
  logic                     core_coeff_ready;

  window_pkg::sample_beat_t core_tdata;
  logic                     core_tvalid;
  logic                     core_tready;

  //////////////////////////////////////////////////
  // Settings and readback
  //////////////////////////////////////////////////

  window_settings #(
    .MAX_LOG2_WINDOW(MAX_LOG2_WINDOW))
  u_settings (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_window_size(window_size),
    .o_coeff(set_coeff), .o_coeff_valid(set_coeff_valid),
    .o_rb_data(o_rb_data));

  // Writes into a full FIFO are lost
  stream_fifo #(
    .payload_t(window_pkg::coeff_beat_t), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2))
  u_coeff_fifo (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_data(set_coeff), .i_valid(set_coeff_valid), .o_ready(),
    .o_data(core_coeff), .o_valid(core_coeff_valid), .i_ready(core_coeff_ready));

  //////////////////////////////////////////////////
  // Sample path
  //////////////////////////////////////////////////

  stream_fifo #(
    .payload_t(window_pkg::sample_beat_t), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2))
  u_in_fifo (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_data(i_tdata), .i_valid(i_tvalid), .o_ready(o_tready),
    .o_data(core_tdata), .o_valid(core_tvalid), .i_ready(core_tready));

  window_core #(
    .MAX_LOG2_WINDOW(MAX_LOG2_WINDOW))
  u_core (
    .i_ce_clk(i_ce_clk), .i_arst_n(i_arst_n),
    .i_window_size(window_size),
    .i_coeff(core_coeff), .i_coeff_valid(core_coeff_valid),
    .o_coeff_ready(core_coeff_ready),
    .i_tdata(core_tdata), .i_tvalid(core_tvalid), .o_tready(core_tready),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready));

endmodule

/* tb/tb_window_tasks.svh */
`ifndef TB_WINDOW_TASKS_SVH
`define TB_WINDOW_TASKS_SVH

//////////////////////////////////////////////////
// Stimulus state and reference model
//////////////////////////////////////////////////

logic [31:0]              data_seed  = 32'd27;
logic [31:0]              ready_seed = 32'd27;
logic signed [15:0]       model_coeff [MAX_WINDOW];
int                       model_size = MAX_WINDOW;
int                       model_pos  = 0;
window_pkg::sample_beat_t exp_q [$];

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Output for one sample at the current model position
function automatic window_pkg::sample_beat_t expected_beat(input window_pkg::sample_beat_t s);
  int                       prod_i;
  int                       prod_q;
  window_pkg::sample_beat_t r;
  prod_i   = int'($signed(s.data_i)) * int'(model_coeff[model_pos]);
  prod_q   = int'($signed(s.data_q)) * int'(model_coeff[model_pos]);
  r.data_i = 16'(prod_i >>> 15);
  r.data_q = 16'(prod_q >>> 15);
  r.last   = (model_pos == model_size - 1);
  return r;
endfunction

task automatic idle(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
  i_set_stb  = 1'b1;
  i_set_addr = addr;
  i_set_data = data;
  @(posedge clk);
  #1;
  i_set_stb = 1'b0;
endtask

task automatic set_window_size(input logic [31:0] size);
  int eff;
  // Zero or oversize falls back to the maximum
  eff = ((size == 0) || (size > MAX_WINDOW)) ? MAX_WINDOW : int'(size);
  if (eff != model_size) begin
    model_pos = 0;
  end
  model_size = eff;
  write_setting(window_pkg::SR_WINDOW_SIZE, size);
  idle(2);
endtask

task automatic load_coeffs(input int n, input logic full_scale);
  logic [15:0] c;
  int          k;
  for (k = 0; k < n; k++) begin
    data_seed = lcg_next(data_seed);
    c = full_scale ? 16'h7FFF : data_seed[31:16];
    model_coeff[k] = c;
    write_setting((k == n - 1) ? window_pkg::SR_COEFF_LAST : window_pkg::SR_COEFF, 32'(c));
  end
  // Coefficient FIFO empties into the core memory
  idle(4);
endtask

//////////////////////////////////////////////////
// Stream drivers
//////////////////////////////////////////////////

task automatic send_samples(input int n);
  window_pkg::sample_beat_t beat;
  logic                     accepted;
  int                       k;
  for (k = 0; k < n; k++) begin
    data_seed   = lcg_next(data_seed);
    beat.data_i = data_seed[31:16];
    data_seed   = lcg_next(data_seed);
    beat.data_q = data_seed[31:16];
    // Input last is ignored by the core
    beat.last   = data_seed[15];
    exp_q.push_back(expected_beat(beat));
    model_pos = (model_pos == model_size - 1) ? 0 : model_pos + 1;
    i_tdata   = beat;
    i_tvalid  = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = o_tready;
      @(posedge clk);
      #1;
    end
    i_tvalid = 1'b0;
  end
endtask

task automatic wait_drain(input int max_cycles);
  int n;
  n = 0;
  while ((exp_q.size() != 0) && (n < max_cycles)) begin
    @(posedge clk);
    n++;
  end
  #1;
  assert (exp_q.size() == 0) else error_text("output stream did not drain in time");
endtask

`endif

/* tb/tb_noc_block_window.sv */
module tb_noc_block_window;

  localparam int MAX_LOG2_WINDOW = 11;
  localparam int FIFO_DEPTH_LOG2 = 2;
  localparam int MAX_WINDOW      = 1 << MAX_LOG2_WINDOW;
  // Samples sent over all tests
  localparam int TOTAL_SAMPLES   = 16 + 20 + 30 + 5 + 6;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 1000;

  logic                     clk;
  logic                     i_arst_n;
  logic                     i_set_stb;
  logic [7:0]               i_set_addr;
  logic [31:0]              i_set_data;
  logic [63:0]              o_rb_data;
  window_pkg::sample_beat_t i_tdata;
  logic                     i_tvalid;
  logic                     o_tready;
  window_pkg::sample_beat_t o_tdata;
  logic                     o_tvalid;
  logic                     i_tready;

  int                       error_count = 0;
  int                       last_count  = 0;
  logic                     bp_enable   = 1'b0;
  logic                     hold_pending = 1'b0;
  window_pkg::sample_beat_t held_beat;
  window_pkg::sample_beat_t exp_beat;

  `include "tb_window_tasks.svh"

  noc_block_window #(
    .MAX_LOG2_WINDOW(MAX_LOG2_WINDOW), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2))
  u_dut (
    .i_ce_clk(clk), .i_arst_n(i_arst_n),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_rb_data(o_rb_data),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_tvalid(o_tvalid), .i_tready(i_tready));

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic error_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    error_count++;
    $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
             $time, name, exp_v, act_v);
    $display("Done: errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic error_text(input string msg);
    error_count++;
    $display("Error at time %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_readback(input logic [31:0] sel, input logic [63:0] expected);
    write_setting(window_pkg::SR_READBACK, sel);
    assert (o_rb_data == expected) else error_value("o_rb_data", expected, o_rb_data);
  endtask

  // Output ready is random only while back-pressure is on
  always begin
    @(posedge clk);
    #1;
    if (bp_enable) begin
      ready_seed = lcg_next(ready_seed);
      i_tready   = ready_seed[31];
    end else begin
      i_tready = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (i_arst_n) begin
      if (hold_pending) begin
        assert (o_tvalid) else error_text("o_tvalid dropped while output was stalled");
        assert (o_tdata == held_beat) else error_value("o_tdata", held_beat, o_tdata);
      end
      hold_pending = o_tvalid && !i_tready;
      held_beat    = o_tdata;
      if (o_tvalid && i_tready) begin
        assert (exp_q.size() != 0) else error_text("output beat with no sample sent");
        exp_beat = exp_q.pop_front();
        assert (o_tdata.data_i == exp_beat.data_i)
          else error_value("o_tdata.data_i", exp_beat.data_i, o_tdata.data_i);
        assert (o_tdata.data_q == exp_beat.data_q)
          else error_value("o_tdata.data_q", exp_beat.data_q, o_tdata.data_q);
        assert (o_tdata.last == exp_beat.last)
          else error_value("o_tdata.last", exp_beat.last, o_tdata.last);
        last_count += o_tdata.last;
      end
    end
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_defaults();
    assert (o_tvalid == 1'b0) else error_value("o_tvalid", 64'd0, 64'(o_tvalid));
    assert (o_tready == 1'b1) else error_value("o_tready", 64'd1, 64'(o_tready));
    check_readback(0, 64'(MAX_WINDOW));
    check_readback(1, 64'(MAX_WINDOW));
    check_readback(5, window_pkg::RB_ERROR_WORD);
  endtask

  task automatic full_scale_window();
    int lasts_before;
    set_window_size(8);
    load_coeffs(8, 1'b1);
    lasts_before = last_count;
    send_samples(16);
    wait_drain(16 * 20);
    // Outputs 8 and 16 close a window
    assert (last_count - lasts_before == 2)
      else error_value("last count", 64'd2, 64'(last_count - lasts_before));
  endtask

  task automatic random_coeff_window();
    set_window_size(5);
    load_coeffs(5, 1'b0);
    send_samples(20);
    wait_drain(20 * 20);
  endtask

  task automatic backpressure_stream();
    set_window_size(7);
    load_coeffs(7, 1'b0);
    @(negedge clk);
    bp_enable = 1'b1;
    @(posedge clk);
    #1;
    send_samples(30);
    wait_drain(30 * 20);
    @(negedge clk);
    bp_enable = 1'b0;
    idle(2);
  endtask

  task automatic size_clamping();
    set_window_size(0);
    check_readback(1, 64'(MAX_WINDOW));
    set_window_size(100);
    check_readback(1, 64'd100);
    set_window_size(4000);
    check_readback(1, 64'(MAX_WINDOW));
  endtask

  task automatic size_change_midstream();
    int lasts_before;
    set_window_size(8);
    load_coeffs(8, 1'b0);
    lasts_before = last_count;
    // Partial window followed by a shorter size
    send_samples(5);
    wait_drain(5 * 20);
    set_window_size(3);
    send_samples(6);
    wait_drain(6 * 20);
    assert (last_count - lasts_before == 2)
      else error_value("last count", 64'd2, 64'(last_count - lasts_before));
  endtask

  initial begin
    i_arst_n   = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata    = '0;
    i_tvalid   = 1'b0;
    i_tready   = 1'b1;
    held_beat  = '0;
    repeat (5) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    idle(2);
    reset_defaults();
    full_scale_window();
    random_coeff_window();
    backpressure_stream();
    size_clamping();
    size_change_midstream();
    if (error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Checks failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $fatal(1, "Timeout");
  end

endmodule

/* noc_block_window.f */
+incdir+tb
verilog/window_pkg.sv
verilog/setting_reg.sv
verilog/stream_fifo.sv
verilog/window_settings.sv
verilog/window_core.sv
verilog/noc_block_window.sv
tb/tb_noc_block_window.sv

/* Bender.yml */
package:
  name: noc_block_window

sources:
  - files:
      - verilog/window_pkg.sv
      - verilog/setting_reg.sv
      - verilog/stream_fifo.sv
      - verilog/window_settings.sv
      - verilog/window_core.sv
      - verilog/noc_block_window.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_noc_block_window.sv
